// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP       = dcache_state_tb
FILELIST  = vlog.f
OBJ_DIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# status follows the pass line in the simulation output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(OBJ_DIR)

// File: hdl/access_ctrl.sv
/* hit detection, bus operation and snoop response decode, line state
   update and the registered response */

`default_nettype none

`include "dcache_defs.svh"

module access_ctrl import dcache_pkg::*; (
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  input  logic                        req_valid_i,
  input  access_req_t                 req_i,
  input  region_t                     region_i,
  input  line_state_t [`DC_WAYS-1:0]  ways_i,
  input  logic [`DC_WAY_W-1:0]        victim_way_i,
  input  logic                        all_valid_i,
  output logic [`DC_SET_W-1:0]        rd_set_o,
  output logic                        st_we_o,
  output logic [`DC_SET_W-1:0]        st_set_o,
  output logic [`DC_WAY_W-1:0]        st_way_o,
  output line_state_t                 st_wdata_o,
  output logic [`DC_WAYS-1:0]         valid_o,
  output logic                        advance_o,
  output logic                        resp_valid_o,
  output access_resp_t                resp_o,
  output snoop_resp_t                 snp_resp_o
);

  logic [`DC_TAG_W-1:0] req_tag;
  logic [`DC_SET_W-1:0] req_set;
  logic [`DC_WAYS-1:0]  hit_vec;
  logic                 hit;
  logic [`DC_WAY_W-1:0] hit_way;
  line_state_t          hit_line;
  line_state_t          victim_line;
  logic                 is_wr;
  access_resp_t         resp_d;
  snoop_resp_t          snp_d;

  assign req_tag  = req_i.addr[`DC_ADDR_W-1:`DC_OFFSET_W+`DC_SET_W];
  assign req_set  = req_i.addr[`DC_OFFSET_W+`DC_SET_W-1:`DC_OFFSET_W];
  assign rd_set_o = req_set;
  assign st_set_o = req_set;
  assign is_wr    = (req_i.kind == REQ_WR);

  always_comb begin
    hit_way = '0;
    for (int w = 0; w < `DC_WAYS; w++) begin
      valid_o[w] = ways_i[w].valid;
      hit_vec[w] = ways_i[w].valid && (ways_i[w].tag == req_tag);
      if (hit_vec[w]) begin
        hit_way = `DC_WAY_W'(w);
      end
    end
  end

  assign hit         = |hit_vec;
  assign hit_line    = ways_i[hit_way];
  assign victim_line = ways_i[victim_way_i];

  always_comb begin
    st_we_o    = 1'b0;
    st_way_o   = hit_way;
    st_wdata_o = hit_line;
    advance_o  = 1'b0;
    resp_d     = '0;
    snp_d      = '0;
    if (req_valid_i && req_i.kind != REQ_SNOOP && !region_i.cacheable) begin
      // uncached, state untouched
      if (is_wr && region_i.shareable) begin
        resp_d.bus_op = BUS_WRITE_UNIQUE;
      end else if (is_wr) begin
        resp_d.bus_op = BUS_WRITE_NO_SNOOP;
      end else if (region_i.shareable) begin
        resp_d.bus_op = BUS_READ_ONCE;
      end else begin
        resp_d.bus_op = BUS_READ_NO_SNOOP;
      end
    end else if (req_valid_i && (req_i.kind == REQ_RD || req_i.kind == REQ_WR)) begin
      if (hit) begin
        resp_d.hit = 1'b1;
        resp_d.way = hit_way;
        if (is_wr) begin
          // a shared copy must be made unique first
          if (hit_line.shared) begin
            resp_d.bus_op = BUS_CLEAN_UNIQUE;
          end
          st_we_o           = 1'b1;
          st_wdata_o.dirty  = 1'b1;
          st_wdata_o.shared = 1'b0;
        end
      end else begin
        resp_d.bus_op    = is_wr ? BUS_READ_UNIQUE : BUS_READ_SHARED;
        resp_d.way       = victim_way_i;
        resp_d.writeback = victim_line.valid & victim_line.dirty;
        st_we_o          = 1'b1;
        st_way_o         = victim_way_i;
        st_wdata_o       = '{tag: req_tag, valid: 1'b1, dirty: is_wr, shared: 1'b0};
        advance_o        = all_valid_i;
      end
    end else if (req_valid_i && req_i.kind == REQ_SNOOP) begin
      resp_d.hit = hit;
      resp_d.way = hit_way;
      case (req_i.snoop)
        SNP_READ_ONCE, SNP_READ_SHARED, SNP_READ_UNIQUE: begin
          snp_d.is_shared     = hit & hit_line.shared;
          snp_d.pass_dirty    = hit & hit_line.dirty;
          snp_d.data_transfer = hit;
          if (req_i.snoop == SNP_READ_SHARED) begin
            st_we_o           = hit;
            st_wdata_o.shared = 1'b1;
          end else if (req_i.snoop == SNP_READ_UNIQUE) begin
            st_we_o    = hit;
            st_wdata_o = '{tag: hit_line.tag, valid: 1'b0, dirty: 1'b0, shared: 1'b0};
          end
        end
        SNP_CLEAN_INVALID, SNP_MAKE_INVALID: begin
          snp_d.pass_dirty    = hit & hit_line.dirty;
          snp_d.data_transfer = hit & hit_line.dirty;
          st_we_o             = hit;
          st_wdata_o = '{tag: hit_line.tag, valid: 1'b0, dirty: 1'b0, shared: 1'b0};
        end
        default: snp_d.error = 1'b1;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      resp_valid_o <= 1'b0;
    end else begin
      resp_valid_o <= req_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    resp_o     <= resp_d;
    snp_resp_o <= snp_d;
  end

endmodule

`default_nettype wire

// File: hdl/dcache_defs.svh
/* address split, geometry and LFSR widths, reset values of the region bases */

`ifndef DCACHE_DEFS_SVH
`define DCACHE_DEFS_SVH

// address split: tag | set | byte offset
`define DC_ADDR_W   32
`define DC_OFFSET_W 4
`define DC_SET_W    4
`define DC_TAG_W    24

// geometry
`define DC_SETS     16
`define DC_WAYS     4
`define DC_WAY_W    2

// replacement
`define DC_LFSR_W   8

// region base addresses after reset
`define DC_CACHE_BASE_RST  32'h8000_0000
`define DC_SHARED_BASE_RST 32'h0000_0000

`endif

// File: hdl/dcache_pkg.sv
/* request, snoop and bus operation enums; request, line state, region
   and response structs */

`default_nettype none

`include "dcache_defs.svh"

package dcache_pkg;

  typedef enum logic [1:0] {
    REQ_RD,
    REQ_WR,
    REQ_SNOOP
  } req_kind_e;

  // incoming snoop types, other codes are unsupported
  typedef enum logic [3:0] {
    SNP_READ_ONCE     = 4'b0000,
    SNP_READ_SHARED   = 4'b0001,
    SNP_READ_UNIQUE   = 4'b0111,
    SNP_CLEAN_INVALID = 4'b1001,
    SNP_MAKE_INVALID  = 4'b1101
  } snoop_e;

  // transaction the cache issues for a CPU access
  typedef enum logic [2:0] {
    BUS_NONE,
    BUS_READ_SHARED,
    BUS_READ_UNIQUE,
    BUS_CLEAN_UNIQUE,
    BUS_READ_ONCE,
    BUS_READ_NO_SNOOP,
    BUS_WRITE_UNIQUE,
    BUS_WRITE_NO_SNOOP
  } bus_op_e;

  typedef struct packed {
    req_kind_e              kind;
    logic [`DC_ADDR_W-1:0]  addr;
    snoop_e                 snoop;
  } access_req_t;

  typedef struct packed {
    logic [`DC_TAG_W-1:0] tag;
    logic                 valid;
    logic                 dirty;
    logic                 shared;
  } line_state_t;

  typedef struct packed {
    logic cacheable;
    logic shareable;
  } region_t;

  typedef struct packed {
    logic                 hit;
    bus_op_e              bus_op;
    logic                 writeback;
    logic [`DC_WAY_W-1:0] way;
  } access_resp_t;

  typedef struct packed {
    logic is_shared;
    logic pass_dirty;
    logic data_transfer;
    logic error;
  } snoop_resp_t;

endpackage

`default_nettype wire

// File: hdl/dcache_state_top.sv
/* cache coherence state tracker top: region config, line state array,
   victim select and access control */

`default_nettype none

`include "dcache_defs.svh"

module dcache_state_top import dcache_pkg::*; (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  req_valid_i,
  input  access_req_t           req_i,
  input  logic                  cfg_we_i,
  input  logic                  cfg_sel_i,
  input  logic [`DC_ADDR_W-1:0] cfg_data_i,
  output logic                  resp_valid_o,
  output access_resp_t          resp_o,
  output snoop_resp_t           snp_resp_o
);

  region_t                     region;
  line_state_t [`DC_WAYS-1:0]  ways;
  logic [`DC_SET_W-1:0]        rd_set;
  logic                        st_we;
  logic [`DC_SET_W-1:0]        st_set;
  logic [`DC_WAY_W-1:0]        st_way;
  line_state_t                 st_wdata;
  logic [`DC_WAYS-1:0]         set_valid;
  logic                        advance;
  logic [`DC_WAY_W-1:0]        victim_way;
  logic                        all_valid;

  region_cfg region_cfg_inst (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .cfg_we_i   (cfg_we_i),
    .cfg_sel_i  (cfg_sel_i),
    .cfg_data_i (cfg_data_i),
    .addr_i     (req_i.addr),
    .region_o   (region)
  );

  line_state_array line_state_array_inst (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .rd_set_i  (rd_set),
    .we_i      (st_we),
    .wr_set_i  (st_set),
    .wr_way_i  (st_way),
    .wr_data_i (st_wdata),
    .rd_ways_o (ways)
  );

  victim_select victim_select_inst (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .valid_i      (set_valid),
    .advance_i    (advance),
    .victim_way_o (victim_way),
    .all_valid_o  (all_valid)
  );

  access_ctrl access_ctrl_inst (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .req_valid_i  (req_valid_i),
    .req_i        (req_i),
    .region_i     (region),
    .ways_i       (ways),
    .victim_way_i (victim_way),
    .all_valid_i  (all_valid),
    .rd_set_o     (rd_set),
    .st_we_o      (st_we),
    .st_set_o     (st_set),
    .st_way_o     (st_way),
    .st_wdata_o   (st_wdata),
    .valid_o      (set_valid),
    .advance_o    (advance),
    .resp_valid_o (resp_valid_o),
    .resp_o       (resp_o),
    .snp_resp_o   (snp_resp_o)
  );

endmodule

`default_nettype wire

// File: hdl/line_state_array.sv
/* tag, valid, dirty and shared flops for every set and way, with a
   whole-set read port and a single-way write port */

`default_nettype none

`include "dcache_defs.svh"

module line_state_array import dcache_pkg::*; (
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  input  logic [`DC_SET_W-1:0]        rd_set_i,
  input  logic                        we_i,
  input  logic [`DC_SET_W-1:0]        wr_set_i,
  input  logic [`DC_WAY_W-1:0]        wr_way_i,
  input  line_state_t                 wr_data_i,
  output line_state_t [`DC_WAYS-1:0]  rd_ways_o
);

  // one packed row of ways per set
  line_state_t [`DC_WAYS-1:0] lines_q [`DC_SETS];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int s = 0; s < `DC_SETS; s++) begin
        lines_q[s] <= '0;
      end
    end else if (we_i) begin
      lines_q[wr_set_i][wr_way_i] <= wr_data_i;
    end
  end

  // read is combinational, a write shows up after the edge
  assign rd_ways_o = lines_q[rd_set_i];

endmodule

`default_nettype wire

// File: hdl/region_cfg.sv
/* cacheable and shareable base registers with write port, and the
   address classification against them */

`default_nettype none

`include "dcache_defs.svh"

module region_cfg import dcache_pkg::*; (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  cfg_we_i,
  input  logic                  cfg_sel_i,
  input  logic [`DC_ADDR_W-1:0] cfg_data_i,
  input  logic [`DC_ADDR_W-1:0] addr_i,
  output region_t               region_o
);

  logic [`DC_ADDR_W-1:0] cache_base_q;
  logic [`DC_ADDR_W-1:0] shared_base_q;
  logic                  cache_base_we;
  logic                  shared_base_we;

  // sel 0 is the cacheable base, sel 1 the shareable base
  assign cache_base_we  = cfg_we_i & ~cfg_sel_i;
  assign shared_base_we = cfg_we_i & cfg_sel_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cache_base_q <= `DC_CACHE_BASE_RST;
    end else if (cache_base_we) begin
      cache_base_q <= cfg_data_i;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      shared_base_q <= `DC_SHARED_BASE_RST;
    end else if (shared_base_we) begin
      shared_base_q <= cfg_data_i;
    end
  end

  // everything at or above a base belongs to its region
  always_comb begin
    region_o.cacheable = (addr_i >= cache_base_q);
    region_o.shareable = (addr_i >= shared_base_q);
  end

endmodule

`default_nettype wire

// File: hdl/victim_select.sv
/* lowest-free-way priority pick and 8-bit replacement LFSR */

`default_nettype none

`include "dcache_defs.svh"

module victim_select (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic [`DC_WAYS-1:0]  valid_i,
  input  logic                 advance_i,
  output logic [`DC_WAY_W-1:0] victim_way_o,
  output logic                 all_valid_o
);

  logic [`DC_LFSR_W-1:0] lfsr_q;
  logic [`DC_LFSR_W-1:0] lfsr_d;
  logic [`DC_WAY_W-1:0]  free_way;
  logic                  feedback;

  assign all_valid_o = &valid_i;

  // scan down so the lowest invalid way wins
  always_comb begin
    free_way = '0;
    for (int w = `DC_WAYS - 1; w >= 0; w--) begin
      if (!valid_i[w]) begin
        free_way = `DC_WAY_W'(w);
      end
    end
  end

  assign victim_way_o = all_valid_o ? lfsr_q[`DC_WAY_W-1:0] : free_way;

  // xnor taps 7, 3, 2, 1 shifted in at the bottom
  assign feedback = ~(lfsr_q[7] ^ lfsr_q[3] ^ lfsr_q[2] ^ lfsr_q[1]);
  assign lfsr_d   = {lfsr_q[`DC_LFSR_W-2:0], feedback};

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      lfsr_q <= '0;
    end else if (advance_i) begin
      lfsr_q <= lfsr_d;
    end
  end

endmodule

`default_nettype wire

// File: tb/dcache_state_chk.sv
/* concurrent assertions on the request and response ports of the top
   level, bound into it */

`default_nettype none

module dcache_state_chk import dcache_pkg::*; (
  input logic         clk_i,
  input logic         arst_n_i,
  input logic         req_valid_i,
  input logic         resp_valid_o,
  input access_resp_t resp_o,
  input snoop_resp_t  snp_resp_o
);

  timeunit 1ns;
  timeprecision 1ps;

  // one response per strobe, exactly one cycle later
  resp_follows_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    req_valid_i |=> resp_valid_o)
    else $error("resp_valid_o missing one cycle after req_valid_i");

  no_resp_without_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !req_valid_i |=> !resp_valid_o)
    else $error("resp_valid_o without a request");

  // a victim is only written back on a miss
  wb_not_hit: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    resp_valid_o && resp_o.writeback |-> !resp_o.hit)
    else $error("writeback reported together with hit");

  err_no_data: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    resp_valid_o && snp_resp_o.error |-> !snp_resp_o.data_transfer)
    else $error("snoop error reported with data transfer");

  quiet_in_reset: assert property (@(posedge clk_i) !arst_n_i |-> !resp_valid_o)
    else $error("resp_valid_o high during reset");

endmodule

bind dcache_state_top dcache_state_chk dcache_state_chk_inst (
  .clk_i        (clk_i),
  .arst_n_i     (arst_n_i),
  .req_valid_i  (req_valid_i),
  .resp_valid_o (resp_valid_o),
  .resp_o       (resp_o),
  .snp_resp_o   (snp_resp_o)
);

`default_nettype wire

// File: tb/dcache_state_tb.sv
/* testbench for the coherence state tracker: clock, reset, watchdog,
   reference model, directed tests and compare tasks */

`default_nettype none

`include "dcache_defs.svh"

module dcache_state_tb import dcache_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD = 20;
  localparam int RST_CYCLES = 4;
  // requests plus the one config write
  localparam int NUM_REQS   = 45;

  logic                  clk = 1'b0;
  logic                  arst_n;
  logic                  req_valid;
  access_req_t           req;
  logic                  cfg_we;
  logic                  cfg_sel;
  logic [`DC_ADDR_W-1:0] cfg_data;
  logic                  resp_valid;
  access_resp_t          resp;
  snoop_resp_t           snp_resp;

  // reference model
  line_state_t           model_lines [`DC_SETS][`DC_WAYS];
  logic [`DC_LFSR_W-1:0] model_lfsr;
  logic [`DC_ADDR_W-1:0] model_cache_base;
  logic [`DC_ADDR_W-1:0] model_shared_base;

  int seed = 73;
  int n_pass;
  int n_fail;

  always #(CLK_PERIOD / 2) clk = ~clk;

  dcache_state_top dcache_state_top_inst (
    .clk_i        (clk),
    .arst_n_i     (arst_n),
    .req_valid_i  (req_valid),
    .req_i        (req),
    .cfg_we_i     (cfg_we),
    .cfg_sel_i    (cfg_sel),
    .cfg_data_i   (cfg_data),
    .resp_valid_o (resp_valid),
    .resp_o       (resp),
    .snp_resp_o   (snp_resp)
  );

  function automatic logic [`DC_ADDR_W-1:0] line_addr(input logic [`DC_TAG_W-1:0] tag,
                                                      input logic [`DC_SET_W-1:0] set);
    return {tag, set, `DC_OFFSET_W'(0)};
  endfunction

  // top bit set keeps the line above the cacheable base
  function automatic logic [`DC_TAG_W-1:0] rand_tag();
    return {1'b1, 23'($random(seed))};
  endfunction

  function automatic access_req_t make_req(input req_kind_e kind,
                                           input logic [`DC_ADDR_W-1:0] addr,
                                           input snoop_e snp);
    return '{kind: kind, addr: addr, snoop: snp};
  endfunction

  task automatic check_resp(input access_resp_t got, input access_resp_t exp,
                            input string what);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t ns: %s got hit=%0b op=%0d wb=%0b way=%0d",
               $time, what, got.hit, got.bus_op, got.writeback, got.way);
      $display("  expected hit=%0b op=%0d wb=%0b way=%0d",
               exp.hit, exp.bus_op, exp.writeback, exp.way);
      n_fail++;
    end else begin
      n_pass++;
    end
  endtask

  task automatic check_snoop(input snoop_resp_t got, input snoop_resp_t exp,
                             input string what);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t ns: %s got flags %4b, expected %4b",
               $time, what, got, exp);
      n_fail++;
    end else begin
      n_pass++;
    end
  endtask

  // expected result from the line state before the update, then the update
  task automatic model_access(input access_req_t r, output access_resp_t er,
                              output snoop_resp_t es);
    logic [`DC_TAG_W-1:0] tag;
    logic [`DC_SET_W-1:0] set;
    line_state_t          ln;
    logic                 is_wr;
    int                   hw;
    int                   way;
    int                   w;
    tag   = r.addr[`DC_ADDR_W-1:`DC_OFFSET_W+`DC_SET_W];
    set   = r.addr[`DC_OFFSET_W+`DC_SET_W-1:`DC_OFFSET_W];
    is_wr = (r.kind == REQ_WR);
    er    = '0;
    es    = '0;
    ln    = '0;
    hw    = -1;
    for (w = 0; w < `DC_WAYS; w++) begin
      if (model_lines[set][w].valid && model_lines[set][w].tag == tag) begin
        hw = w;
      end
    end
    if (hw >= 0) begin
      ln = model_lines[set][hw];
    end
    if (r.kind == REQ_SNOOP) begin
      case (r.snoop)
        SNP_READ_ONCE, SNP_READ_SHARED, SNP_READ_UNIQUE: begin
          es.is_shared     = ln.shared;
          es.pass_dirty    = ln.dirty;
          es.data_transfer = (hw >= 0);
        end
        SNP_CLEAN_INVALID, SNP_MAKE_INVALID: begin
          es.pass_dirty    = ln.dirty;
          es.data_transfer = ln.dirty;
        end
        default: es.error = 1'b1;
      endcase
      if (hw >= 0 && r.snoop == SNP_READ_SHARED) begin
        model_lines[set][hw].shared = 1'b1;
      end else if (hw >= 0 && r.snoop inside {SNP_READ_UNIQUE, SNP_CLEAN_INVALID,
                                             SNP_MAKE_INVALID}) begin
        model_lines[set][hw] = '0;
      end
    end else if (r.addr < model_cache_base) begin
      if (is_wr) begin
        er.bus_op = (r.addr >= model_shared_base) ? BUS_WRITE_UNIQUE : BUS_WRITE_NO_SNOOP;
      end else begin
        er.bus_op = (r.addr >= model_shared_base) ? BUS_READ_ONCE : BUS_READ_NO_SNOOP;
      end
    end else if (hw >= 0) begin
      er.hit = 1'b1;
      er.way = `DC_WAY_W'(hw);
      if (is_wr) begin
        er.bus_op = ln.shared ? BUS_CLEAN_UNIQUE : BUS_NONE;
        model_lines[set][hw].dirty  = 1'b1;
        model_lines[set][hw].shared = 1'b0;
      end
    end else begin
      er.bus_op = is_wr ? BUS_READ_UNIQUE : BUS_READ_SHARED;
      way = -1;
      for (w = `DC_WAYS - 1; w >= 0; w--) begin
        if (!model_lines[set][w].valid) begin
          way = w;
        end
      end
      if (way < 0) begin
        way        = int'(model_lfsr[`DC_WAY_W-1:0]);
        model_lfsr = {model_lfsr[6:0],
                      ~(model_lfsr[7] ^ model_lfsr[3] ^ model_lfsr[2] ^ model_lfsr[1])};
      end
      er.way       = `DC_WAY_W'(way);
      er.writeback = model_lines[set][way].valid & model_lines[set][way].dirty;
      model_lines[set][way] = '{tag: tag, valid: 1'b1, dirty: is_wr, shared: 1'b0};
    end
  endtask

  task automatic compare_result(input req_kind_e kind, input access_resp_t er,
                                input snoop_resp_t es, input string what);
    if (!resp_valid) begin
      $display("%0t ns: no response for %s, resp_valid_o stayed low", $time, what);
      n_fail++;
    end else if (kind == REQ_SNOOP) begin
      check_snoop(snp_resp, es, what);
    end else begin
      check_resp(resp, er, what);
    end
  endtask

  task automatic send(input access_req_t r, input string what);
    access_resp_t er;
    snoop_resp_t  es;
    model_access(r, er, es);
    @(posedge clk);
    req_valid <= 1'b1;
    req       <= r;
    @(posedge clk);
    req_valid <= 1'b0;
    @(negedge clk);
    compare_result(r.kind, er, es, what);
  endtask

  // second request goes out in the cycle the first one is answered
  task automatic send_pair(input access_req_t a, input access_req_t b, input string what);
    access_resp_t era;
    access_resp_t erb;
    snoop_resp_t  esa;
    snoop_resp_t  esb;
    model_access(a, era, esa);
    model_access(b, erb, esb);
    @(posedge clk);
    req_valid <= 1'b1;
    req       <= a;
    @(posedge clk);
    req       <= b;
    @(negedge clk);
    compare_result(a.kind, era, esa, {what, " first"});
    @(posedge clk);
    req_valid <= 1'b0;
    @(negedge clk);
    compare_result(b.kind, erb, esb, {what, " second"});
  endtask

  task automatic write_cfg(input logic sel, input logic [`DC_ADDR_W-1:0] data);
    @(posedge clk);
    cfg_we   <= 1'b1;
    cfg_sel  <= sel;
    cfg_data <= data;
    @(posedge clk);
    cfg_we <= 1'b0;
    if (sel) begin
      model_shared_base = data;
    end else begin
      model_cache_base = data;
    end
  endtask

  task automatic report(input string name, input int fails_before);
    $display("test %s: %s", name, (n_fail == fails_before) ? "ok" : "errors");
  endtask

  task automatic test_noncacheable();
    int f0;
    f0 = n_fail;
    send(make_req(REQ_RD, 32'h1000_0040, SNP_READ_ONCE), "uncached shareable read");
    send(make_req(REQ_WR, 32'h1000_0080, SNP_READ_ONCE), "uncached shareable write");
    // move the shareable base above the address
    write_cfg(1'b1, 32'h2000_0000);
    send(make_req(REQ_RD, 32'h1000_0040, SNP_READ_ONCE), "uncached private read");
    send(make_req(REQ_WR, 32'h1000_0080, SNP_READ_ONCE), "uncached private write");
    report("non-cacheable", f0);
  endtask

  task automatic test_fill_hit();
    logic [`DC_TAG_W-1:0] tags [`DC_WAYS];
    int                   f0;
    int                   i;
    f0 = n_fail;
    for (i = 0; i < `DC_WAYS; i++) begin
      tags[i] = rand_tag();
      send(make_req(REQ_RD, line_addr(tags[i], 4'h1), SNP_READ_ONCE), "fill read miss");
    end
    for (i = 0; i < `DC_WAYS; i++) begin
      send(make_req(REQ_RD, line_addr(tags[i], 4'h1), SNP_READ_ONCE), "read hit");
    end
    send(make_req(REQ_WR, line_addr(rand_tag(), 4'h2), SNP_READ_ONCE), "write miss");
    report("fill and hit", f0);
  endtask

  task automatic test_replacement();
    int f0;
    int i;
    f0 = n_fail;
    // set 1 is full, writes leave dirty victims for later rounds
    for (i = 0; i < 8; i++) begin
      send(make_req(i[0] ? REQ_WR : REQ_RD, line_addr(rand_tag(), 4'h1), SNP_READ_ONCE),
           "replacement miss");
    end
    report("replacement", f0);
  endtask

  task automatic test_shared_write();
    logic [`DC_ADDR_W-1:0] a;
    int                    f0;
    f0 = n_fail;
    a  = line_addr(rand_tag(), 4'h5);
    send(make_req(REQ_RD, a, SNP_READ_ONCE), "allocate");
    send(make_req(REQ_SNOOP, a, SNP_READ_SHARED), "snoop read shared");
    send(make_req(REQ_WR, a, SNP_READ_ONCE), "write to shared line");
    send(make_req(REQ_WR, a, SNP_READ_ONCE), "write to unique line");
    report("shared write", f0);
  endtask

  task automatic test_snoops();
    logic [`DC_ADDR_W-1:0] a;
    logic [`DC_ADDR_W-1:0] b;
    int                    f0;
    f0 = n_fail;
    a  = line_addr(rand_tag(), 4'h6);
    b  = line_addr(rand_tag(), 4'h6);
    send(make_req(REQ_SNOOP, a, SNP_READ_ONCE), "read once miss");
    send(make_req(REQ_RD, a, SNP_READ_ONCE), "allocate clean");
    send(make_req(REQ_SNOOP, a, SNP_READ_ONCE), "read once clean hit");
    send(make_req(REQ_SNOOP, a, SNP_READ_SHARED), "read shared clean hit");
    send(make_req(REQ_WR, a, SNP_READ_ONCE), "make dirty");
    send(make_req(REQ_SNOOP, a, SNP_READ_ONCE), "read once dirty hit");
    send(make_req(REQ_SNOOP, a, SNP_READ_UNIQUE), "read unique dirty hit");
    send(make_req(REQ_RD, a, SNP_READ_ONCE), "read after read unique");
    send(make_req(REQ_WR, b, SNP_READ_ONCE), "allocate dirty");
    send(make_req(REQ_SNOOP, b, SNP_CLEAN_INVALID), "clean invalid dirty hit");
    send(make_req(REQ_RD, b, SNP_READ_ONCE), "read after clean invalid");
    send(make_req(REQ_SNOOP, b, SNP_MAKE_INVALID), "make invalid clean hit");
    send(make_req(REQ_SNOOP, b, SNP_MAKE_INVALID), "make invalid miss");
    // the line must be gone after make invalid
    send(make_req(REQ_RD, b, SNP_READ_ONCE), "read after make invalid");
    send(make_req(REQ_SNOOP, a, snoop_e'(4'h3)), "unsupported snoop");
    report("snoop responses", f0);
  endtask

  task automatic test_back_to_back();
    logic [`DC_ADDR_W-1:0] a;
    int                    f0;
    f0 = n_fail;
    a  = line_addr(rand_tag(), 4'h7);
    send_pair(make_req(REQ_WR, a, SNP_READ_ONCE), make_req(REQ_RD, a, SNP_READ_ONCE),
              "write miss then read");
    send_pair(make_req(REQ_SNOOP, a, SNP_READ_UNIQUE), make_req(REQ_RD, a, SNP_READ_ONCE),
              "read unique then read");
    report("back to back", f0);
  endtask

  initial begin
    arst_n    = 1'b0;
    req_valid = 1'b0;
    req       = '0;
    cfg_we    = 1'b0;
    cfg_sel   = 1'b0;
    cfg_data  = '0;
    n_pass    = 0;
    n_fail    = 0;
    for (int s = 0; s < `DC_SETS; s++) begin
      for (int w = 0; w < `DC_WAYS; w++) begin
        model_lines[s][w] = '0;
      end
    end
    model_lfsr        = '0;
    model_cache_base  = `DC_CACHE_BASE_RST;
    model_shared_base = `DC_SHARED_BASE_RST;
    repeat (RST_CYCLES) @(posedge clk);
    arst_n <= 1'b1;
    test_noncacheable();
    test_fill_hit();
    test_replacement();
    test_shared_write();
    test_snoops();
    test_back_to_back();
    $display("checks passed: %0d, failed: %0d", n_pass, n_fail);
    if (n_fail == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // each request takes well under 4 cycles
  initial begin
    #((NUM_REQS * 4 + RST_CYCLES) * CLK_PERIOD);
    $display("timeout: the tests did not finish in time");
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+hdl
hdl/dcache_pkg.sv
hdl/region_cfg.sv
hdl/line_state_array.sv
hdl/victim_select.sv
hdl/access_ctrl.sv
hdl/dcache_state_top.sv
tb/dcache_state_chk.sv
tb/dcache_state_tb.sv
